/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module stoch_mul_tb -f build.f -o stoch_mul_sim
	./obj_dir/stoch_mul_sim | awk '{ print } /^Result: PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* build.f */
+incdir+verif
design/stoch_pkg.sv
design/mul_ctrl.sv
design/sng.sv
design/stream_buffer.sv
design/stoch_decode.sv
design/stoch_mul_top.sv
verif/stoch_mul_tb.sv

/* design/mul_ctrl.sv */
`timescale 1ns/1ps

module mul_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cfg_wr,
   input  stoch_pkg::cfg_t      cfg,
   input  logic                 start,
   output logic                 busy,
   output logic                 done,
   output stoch_pkg::phase_ctrl_t ph,
   output stoch_pkg::cfg_t      op
);

   localparam int MAX_PHASE = (stoch_pkg::FILL_CYCLES > stoch_pkg::ACC_CYCLES) ?
                              stoch_pkg::FILL_CYCLES : stoch_pkg::ACC_CYCLES;
   localparam int CYC_W = $clog2(MAX_PHASE);

   localparam logic [CYC_W-1:0] FILL_LAST = CYC_W'(stoch_pkg::FILL_CYCLES - 1);
   localparam logic [CYC_W-1:0] ACC_LAST = CYC_W'(stoch_pkg::ACC_CYCLES - 1);

   typedef enum logic [2:0] {
      S_IDLE,
      S_CLEAR,
      S_FILL,
      S_ACC,
      S_CAPT
   } state_t;

   state_t           state;
   logic [CYC_W-1:0] cyc;

   assign busy = (state != S_IDLE);

   // operands only change between jobs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op <= '0;
      end else if (cfg_wr && !busy) begin
         op <= cfg;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= S_IDLE;
         cyc   <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start) begin
                  state <= S_CLEAR;
               end
            end
            S_CLEAR: begin
               state <= S_FILL;
               cyc   <= '0;
            end
            S_FILL: begin
               if (cyc == FILL_LAST) begin
                  state <= S_ACC;
                  cyc   <= '0;
               end else begin
                  cyc <= cyc + 1'b1;
               end
            end
            S_ACC: begin
               if (cyc == ACC_LAST) begin
                  state <= S_CAPT;
                  cyc   <= '0;
               end else begin
                  cyc <= cyc + 1'b1;
               end
            end
            S_CAPT: begin
               state <= S_IDLE;
               done  <= 1'b1;   // lines up with the new result
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_comb begin
      ph = '0;
      case (state)
         S_CLEAR: ph.clear = 1'b1;
         S_FILL: begin
            ph.gen_en   = 1'b1;
            ph.shift_en = 1'b1;
         end
         S_ACC: begin
            ph.shift_en = 1'b1;
            ph.wrap     = 1'b1;
         end
         S_CAPT: ph.capture = 1'b1;
         default: ph = '0;
      endcase
   end

   // rotating without shifting would count one window over and over
   a_wrap_shifts: assert property (@(posedge clk) disable iff (rst) ph.wrap |-> ph.shift_en);

   a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

/* design/sng.sv */
`timescale 1ns/1ps

module sng #(
   parameter bit BIT_REVERSE = 1'b0
) (
   input  logic                          clk,
   input  logic                          rst,
   input  stoch_pkg::phase_ctrl_t        ph,
   input  logic [stoch_pkg::DATA_W-1:0]  value,
   output logic                          bit_out
);

   logic [stoch_pkg::DATA_W-1:0] cnt;
   logic [stoch_pkg::DATA_W-1:0] cnt_rev;
   logic [stoch_pkg::DATA_W-1:0] ref_val;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt <= '0;
      end else if (ph.clear) begin
         cnt <= '0;
      end else if (ph.gen_en) begin
         cnt <= cnt + 1'b1;   // wraps after one full period
      end
   end

   always_comb begin
      for (int i = 0; i < stoch_pkg::DATA_W; i++) begin
         cnt_rev[i] = cnt[stoch_pkg::DATA_W-1-i];
      end
   end

   // reversed order decorrelates this stream from a plain-count one
   assign ref_val = BIT_REVERSE ? cnt_rev : cnt;

   // high on exactly value of the counter states
   assign bit_out = (value > ref_val);

endmodule

/* design/stoch_decode.sv */
`timescale 1ns/1ps

module stoch_decode (
   input  logic                           clk,
   input  logic                           rst,
   input  stoch_pkg::phase_ctrl_t         ph,
   input  logic [stoch_pkg::LANES-1:0]    win_a,
   input  logic [stoch_pkg::LANES-1:0]    win_b,
   input  logic [stoch_pkg::DATA_W-1:0]   offset,
   output logic [stoch_pkg::RES_W-1:0]    result
);

   logic [stoch_pkg::LANES-1:0]      hit;
   logic [stoch_pkg::LANE_CNT_W-1:0] lane_cnt [stoch_pkg::LANES];
   logic [stoch_pkg::RES_W-1:0]      lane_sum;

   // AND of two stream bits is their product
   assign hit = win_a & win_b;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < stoch_pkg::LANES; i++) begin
            lane_cnt[i] <= '0;
         end
      end else if (ph.clear) begin
         for (int i = 0; i < stoch_pkg::LANES; i++) begin
            lane_cnt[i] <= '0;
         end
      end else if (ph.wrap) begin
         for (int i = 0; i < stoch_pkg::LANES; i++) begin
            if (hit[i]) begin
               lane_cnt[i] <= lane_cnt[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      lane_sum = '0;
      for (int i = 0; i < stoch_pkg::LANES; i++) begin
         lane_sum = lane_sum + stoch_pkg::RES_W'(lane_cnt[i]);
      end
   end

   // held until the next capture
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
      end else if (ph.capture) begin
         result <= lane_sum + stoch_pkg::RES_W'(offset);
      end
   end

   // the accumulate phase must last no more than one rotation
   for (genvar g = 0; g < stoch_pkg::LANES; g++) begin : g_lane_chk
      a_lane_bound: assert property (@(posedge clk) disable iff (rst)
         lane_cnt[g] <= stoch_pkg::LANE_CNT_W'(stoch_pkg::SR_LEN));
   end

endmodule

/* design/stoch_mul_top.sv */
`timescale 1ns/1ps

module stoch_mul_top (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cfg_wr,
   input  stoch_pkg::cfg_t               cfg,
   input  logic                          start,
   output logic                          busy,
   output logic                          done,
   output logic [stoch_pkg::RES_W-1:0]   result
);

   stoch_pkg::phase_ctrl_t      ph;
   stoch_pkg::cfg_t             op;
   logic                        bit_a;
   logic                        bit_b;
   logic [stoch_pkg::LANES-1:0] win_a;
   logic [stoch_pkg::LANES-1:0] win_b;

   mul_ctrl u_ctrl (
      .clk    (clk),
      .rst    (rst),
      .cfg_wr (cfg_wr),
      .cfg    (cfg),
      .start  (start),
      .busy   (busy),
      .done   (done),
      .ph     (ph),
      .op     (op)
   );

   // a follows the plain count
   sng #(.BIT_REVERSE(1'b0)) u_sng_a (
      .clk     (clk),
      .rst     (rst),
      .ph      (ph),
      .value   (op.a),
      .bit_out (bit_a)
   );

   // b follows the reversed count
   sng #(.BIT_REVERSE(1'b1)) u_sng_b (
      .clk     (clk),
      .rst     (rst),
      .ph      (ph),
      .value   (op.b),
      .bit_out (bit_b)
   );

   stream_buffer u_buf_a (
      .clk     (clk),
      .rst     (rst),
      .ph      (ph),
      .scan_in (bit_a),
      .window  (win_a)
   );

   stream_buffer u_buf_b (
      .clk     (clk),
      .rst     (rst),
      .ph      (ph),
      .scan_in (bit_b),
      .window  (win_b)
   );

   stoch_decode u_dec (
      .clk    (clk),
      .rst    (rst),
      .ph     (ph),
      .win_a  (win_a),
      .win_b  (win_b),
      .offset (op.c),
      .result (result)
   );

endmodule

/* design/stoch_pkg.sv */
package stoch_pkg;

   // operand and stream geometry
   localparam int DATA_W = 5;
   localparam int SR_LEN = 2 ** DATA_W;   // one full generator period
   localparam int LANES = 8;
   localparam int LANE_CNT_W = $clog2(SR_LEN + 1);   // must hold SR_LEN itself
   localparam int RES_W = 10;

   // phase lengths in clock cycles
   localparam int FILL_CYCLES = SR_LEN;
   localparam int ACC_CYCLES = SR_LEN;

   // operands, c is the offset added after the product
   typedef struct packed {
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] c;
   } cfg_t;

   typedef struct packed {
      logic clear;      // sync clear of datapath state
      logic gen_en;     // generator counters step
      logic shift_en;   // stream registers move
      logic wrap;       // recirculate, also gates the lane counters
      logic capture;    // decoder latches result
   } phase_ctrl_t;

endpackage

/* design/stream_buffer.sv */
`timescale 1ns/1ps

module stream_buffer (
   input  logic                         clk,
   input  logic                         rst,
   input  stoch_pkg::phase_ctrl_t       ph,
   input  logic                         scan_in,
   output logic [stoch_pkg::LANES-1:0]  window
);

   logic [stoch_pkg::SR_LEN-1:0] sr;
   logic                         sr_in;

   // top bit feeds back during accumulate
   assign sr_in = ph.wrap ? sr[stoch_pkg::SR_LEN-1] : scan_in;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sr <= '0;
      end else if (ph.clear) begin
         sr <= '0;
      end else if (ph.shift_en) begin
         sr <= {sr[stoch_pkg::SR_LEN-2:0], sr_in};
      end
   end

   // oldest LANES bits, first sample at the very top
   assign window = sr[stoch_pkg::SR_LEN-1 -: stoch_pkg::LANES];

endmodule

/* verif/stoch_mul_ref.svh */
`ifndef STOCH_MUL_REF_SVH
`define STOCH_MUL_REF_SVH

// bit of stream a at step t, plain count order
function automatic bit stream_bit_a(
   input logic [stoch_pkg::DATA_W-1:0] a,
   input int                           t
);
   logic [stoch_pkg::DATA_W-1:0] step;
   step = stoch_pkg::DATA_W'(t);
   return (a > step);
endfunction

// bit of stream b at step t, compared with the mirrored step number
function automatic bit stream_bit_b(
   input logic [stoch_pkg::DATA_W-1:0] b,
   input int                           t
);
   logic [stoch_pkg::DATA_W-1:0] step;
   logic [stoch_pkg::DATA_W-1:0] step_rev;
   step = stoch_pkg::DATA_W'(t);
   for (int i = 0; i < stoch_pkg::DATA_W; i++) begin
      step_rev[stoch_pkg::DATA_W-1-i] = step[i];
   end
   return (b > step_rev);
endfunction

// LANES times the coincidences over one period, plus the offset
function automatic logic [stoch_pkg::RES_W-1:0] expected_result(
   input logic [stoch_pkg::DATA_W-1:0] a,
   input logic [stoch_pkg::DATA_W-1:0] b,
   input logic [stoch_pkg::DATA_W-1:0] c
);
   int both;
   both = 0;
   for (int t = 0; t < stoch_pkg::SR_LEN; t++) begin
      if (stream_bit_a(a, t) && stream_bit_b(b, t)) begin
         both++;
      end
   end
   // every lane passes each stored position once per rotation
   return stoch_pkg::RES_W'(stoch_pkg::LANES * both + int'(c));
endfunction

`endif

/* verif/stoch_mul_tb.sv */
`timescale 1ns/1ps

module stoch_mul_tb;

   localparam int CLK_HALF = 50;
   localparam int DRIVE_DLY = 10;
   localparam int RESET_CYCLES = 5;
   localparam int DONE_LATENCY = 66;
   localparam int N_DIRECTED = 5;
   localparam int N_RANDOM = 40;
   localparam int N_CHAINED = 4;
   // busy test runs two jobs plus a quiet window of about one job
   localparam int N_OPS = N_DIRECTED + N_RANDOM + 3 + N_CHAINED;
   localparam int TIMEOUT_CYCLES = N_OPS * 70 + 200;

   logic                        clk;
   logic                        rst;
   logic                        cfg_wr;
   stoch_pkg::cfg_t             cfg;
   logic                        start;
   logic                        busy;
   logic                        done;
   logic [stoch_pkg::RES_W-1:0] result;

   int seed = 99510;
   int errors = 0;
   int checks = 0;
   int ops_started = 0;
   int ops_done = 0;
   int cycle_cnt = 0;
   stoch_pkg::cfg_t held_cfg = '0;   // what the DUT should hold
   logic [stoch_pkg::RES_W-1:0] expect_q [$];

   int unsigned edge_num = 0;
   int unsigned start_edge = 0;
   bit          job_open = 1'b0;
   bit          done_prev = 1'b0;

   `include "stoch_mul_ref.svh"

   stoch_mul_top uut (
      .clk    (clk),
      .rst    (rst),
      .cfg_wr (cfg_wr),
      .cfg    (cfg),
      .start  (start),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   always #CLK_HALF clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   function automatic stoch_pkg::cfg_t make_cfg(input int a, input int b, input int c);
      stoch_pkg::cfg_t v;
      v.a = stoch_pkg::DATA_W'(a);
      v.b = stoch_pkg::DATA_W'(b);
      v.c = stoch_pkg::DATA_W'(c);
      return v;
   endfunction

   function automatic stoch_pkg::cfg_t random_cfg();
      logic [31:0] rnd;
      rnd = $random(seed);
      return stoch_pkg::cfg_t'(rnd[$bits(stoch_pkg::cfg_t)-1:0]);
   endfunction

   // one start cycle, optionally with a new configuration
   task automatic launch(input stoch_pkg::cfg_t op_cfg, input bit write_cfg);
      check_value("busy", 32'(busy), 32'd0);
      if (write_cfg) begin
         cfg      = op_cfg;
         cfg_wr   = 1'b1;
         held_cfg = op_cfg;
      end
      start = 1'b1;
      expect_q.push_back(expected_result(held_cfg.a, held_cfg.b, held_cfg.c));
      ops_started++;
      next_cycle();
      cfg_wr = 1'b0;
      start  = 1'b0;
   endtask

   task automatic wait_done();
      while (done !== 1'b1) begin
         next_cycle();
      end
   endtask

   task automatic run_op(input stoch_pkg::cfg_t op_cfg, input bit write_cfg);
      launch(op_cfg, write_cfg);
      wait_done();   // returns inside the done cycle
   endtask

   // compare process, samples on the edge before anything updates
   always @(posedge clk) begin
      edge_num++;
      if (rst) begin
         done_prev = 1'b0;
         job_open  = 1'b0;
      end else begin
         if (done) begin
            if (done_prev) begin
               report_error("done stayed high for more than one cycle");
            end
            if (!job_open || expect_q.size() == 0) begin
               report_error("done pulsed with no operation pending");
            end else begin
               check_value("result", 32'(result), 32'(expect_q.pop_front()));
               check_value("done_latency", 32'(edge_num - start_edge - 1), 32'(DONE_LATENCY));
               check_value("busy", 32'(busy), 32'd0);   // falls with done
               job_open = 1'b0;
               ops_done++;
            end
         end else if (job_open && edge_num > start_edge) begin
            check_value("busy", 32'(busy), 32'd1);
         end
         if (start && !busy) begin
            job_open   = 1'b1;
            start_edge = edge_num;
         end
         done_prev = done;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: no finish after %0d cycles, %0d of %0d operations done",
                  cycle_cnt, ops_done, ops_started);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      clk    = 1'b0;
      rst    = 1'b1;
      cfg_wr = 1'b0;
      cfg    = '0;
      start  = 1'b0;
      repeat (RESET_CYCLES) next_cycle();
      rst = 1'b0;
      next_cycle();

      check_value("busy", 32'(busy), 32'd0);
      check_value("done", 32'(done), 32'd0);
      check_value("result", 32'(result), 32'd0);

      // corner operands
      next_cycle();
      run_op(make_cfg(0, 17, 3), 1'b1);
      next_cycle();
      run_op(make_cfg(22, 0, 5), 1'b1);
      next_cycle();
      run_op(make_cfg(31, 31, 0), 1'b1);
      next_cycle();
      run_op(make_cfg(31, 1, 0), 1'b1);
      next_cycle();
      run_op(make_cfg(0, 0, 31), 1'b1);

      for (int i = 0; i < N_RANDOM; i++) begin
         next_cycle();
         run_op(random_cfg(), 1'b1);
      end

      // writes and starts during a job must be dropped
      next_cycle();
      launch(make_cfg(21, 13, 7), 1'b1);
      repeat (20) next_cycle();
      cfg    = make_cfg(3, 30, 1);
      cfg_wr = 1'b1;
      start  = 1'b1;
      next_cycle();
      cfg_wr = 1'b0;
      start  = 1'b0;
      wait_done();
      repeat (70) next_cycle();   // a stray done would show up here
      run_op(held_cfg, 1'b0);     // operands still the first ones

      // each start lands in the done cycle of the previous job
      for (int i = 0; i < N_CHAINED; i++) begin
         run_op(random_cfg(), 1'b1);
      end

      repeat (3) next_cycle();
      check_value("ops_done", 32'(ops_done), 32'(ops_started));
      check_value("pending", 32'(expect_q.size()), 32'd0);

      $display("checks: %0d  errors: %0d  operations: %0d", checks, errors, ops_done);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
